// File: icache_patterns.txt
// columns: test, fetch address, mode (0 fetch, 1 flush in refill, 2 back-pressure),
// expected burst count after the fetch; all values hex
1 00000110 0 1
1 00000114 0 1
2 00000118 0 1
2 0000011c 0 1
2 00000110 0 1
3 00001020 0 2
3 00002024 0 3
3 00001028 0 3
3 0000302c 0 4
3 00001024 0 4
3 00002028 0 5
3 00001020 0 5
4 00001020 2 5
4 00000530 2 6
4 00000534 0 6
5 00000640 1 7
5 00000644 0 8
5 00000648 0 8
5 00000110 0 8

// File: list.f
icache_pkg.sv
icache_ram.sv
icache_lookup.sv
icache_refill.sv
icache_top.sv
tb_axi_mem.sv
tb_icache.sv

// File: run.sh
#!/bin/bash
# build and run from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_icache -f list.f -o vtb_icache \
  && ./obj_dir/vtb_icache > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "STATUS: PASS" sim.log && exit 0 || exit 1

// File: tb_icache.sv
`default_nettype none

module tb_icache;

  timeunit 1ns;
  timeprecision 1ps;

  import icache_pkg::*;

  localparam int PAT_MAX  = 32;
  localparam int RAND_NUM = 24;

  logic              clk;
  logic              rst_n;
  logic              flush_i;
  logic              req_valid_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic              req_ready_o;
  logic              rsp_valid_o;
  logic [WORD_W-1:0] rsp_instr_o;
  logic              rsp_ready_i;
  logic              ar_valid_o;
  logic [ADDR_W-1:0] ar_addr_o;
  logic              ar_ready_i;
  logic              r_valid_i;
  logic [WORD_W-1:0] r_data_i;
  logic              r_last_i;
  logic              r_ready_o;

  logic [31:0]       pat [PAT_MAX*4];
  logic [31:0]       lfsr;
  int                burst_count;
  logic [ADDR_W-1:0] last_ar_addr;
  int                beat_err;
  int                cycles;
  int                cycle_limit;
  int                errors;
  int                test_err;
  int                tests_pass;
  int                tests_fail;
  int                n_lines;
  int                cur_test;

  icache_top i_dut (.*);

  tb_axi_mem i_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid_o),
    .ar_addr_i  (ar_addr_o),
    .ar_ready_o (ar_ready_i),
    .r_valid_o  (r_valid_i),
    .r_data_o   (r_data_i),
    .r_last_o   (r_last_i),
    .r_ready_i  (r_ready_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // handshake is stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && ar_valid_o && ar_ready_i) begin
      burst_count  <= burst_count + 1;
      last_ar_addr <= ar_addr_o;
    end
    // the memory model sends a beat every cycle of the data phase
    if (rst_n) begin
      assert (r_ready_o == r_valid_i) else begin
        $display("r_ready does not follow the data beats in cycle %0d", cycles);
        beat_err <= beat_err + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the cache stopped answering", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] expected_word(input logic [31:0] a);
    return (a >> 2) ^ 32'hdd90dd90;
  endfunction

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic close_test(input int tnum);
    if (test_err == 0) begin
      $display("test %0d passed", tnum);
      tests_pass++;
    end else begin
      $display("test %0d failed with %0d errors", tnum, test_err);
      tests_fail++;
    end
    errors += test_err;
    test_err = 0;
  endtask

  // mode 0 plain fetch, 1 flush during refill, 2 hold rsp_ready low
  task automatic run_fetch(input int tnum, input logic [31:0] addr, input int mode,
                           input bit chk_cnt, input int exp_cnt);
    int          cnt_before;
    logic [31:0] got;
    cnt_before = burst_count;
    rsp_ready_i = (mode != 2);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    do @(negedge clk); while (!req_ready_o);
    @(posedge clk);
    #1 req_valid_i = 1'b0;
    if (mode == 1) begin
      wait (burst_count != cnt_before);
      @(posedge clk);
      #1 flush_i = 1'b1;
      @(posedge clk);
      #1 flush_i = 1'b0;
      do begin
        @(negedge clk);
        assert (!rsp_valid_o) else begin
          $display("test %0d: response returned for a flushed fetch %h", tnum, addr);
          test_err++;
        end
      end while (!req_ready_o);
    end else begin
      do @(negedge clk); while (!rsp_valid_o);
      got = rsp_instr_o;
      assert (got == expected_word(addr)) else begin
        $display("Error: test %0d fetch %h expected %h actual %h",
                 tnum, addr, expected_word(addr), got);
        test_err++;
      end
      if (mode == 2) begin
        @(posedge clk);
        #1;
        req_valid_i = 1'b1;
        req_addr_i  = addr + 32'h100;
        repeat (5) begin
          @(negedge clk);
          assert (rsp_valid_o && rsp_instr_o == got) else begin
            $display("test %0d: response changed while rsp_ready was low", tnum);
            test_err++;
          end
          assert (!req_ready_o) else begin
            $display("test %0d: new request accepted under back-pressure", tnum);
            test_err++;
          end
        end
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
        rsp_ready_i = 1'b1;
        @(negedge clk);
      end
    end
    @(posedge clk);
    #1;
    if (chk_cnt) begin
      assert (burst_count == exp_cnt) else begin
        $display("Error: test %0d burst count at %h expected %0d actual %0d",
                 tnum, addr, exp_cnt, burst_count);
        test_err++;
      end
      if (burst_count > cnt_before) begin
        assert (last_ar_addr == ((addr >> OFS_W) << OFS_W)) else begin
          $display("Error: test %0d burst address expected %h actual %h",
                   tnum, (addr >> OFS_W) << OFS_W, last_ar_addr);
          test_err++;
        end
      end
    end
  endtask

  // back-to-back random fetches, responses matched in request order
  task automatic run_stream(input int tnum, input int n);
    logic [31:0] word_addr;
    logic [31:0] exp_addr;
    logic [31:0] pending [$];
    int          sent;
    int          got_num;
    bit          take;
    sent    = 0;
    got_num = 0;
    rsp_ready_i = 1'b1;
    take_bits(10, word_addr);
    req_addr_i  = word_addr << 2;
    req_valid_i = 1'b1;
    while (got_num < n) begin
      @(negedge clk);
      take = req_valid_i && req_ready_o;
      if (rsp_valid_o) begin
        assert (pending.size() > 0) else begin
          $display("test %0d: response with no fetch outstanding", tnum);
          test_err++;
        end
        if (pending.size() > 0) begin
          exp_addr = pending.pop_front();
          assert (rsp_instr_o == expected_word(exp_addr)) else begin
            $display("Error: test %0d fetch %h expected %h actual %h",
                     tnum, exp_addr, expected_word(exp_addr), rsp_instr_o);
            test_err++;
          end
        end
        got_num++;
      end
      if (take) begin
        pending.push_back(req_addr_i);
        sent++;
      end
      @(posedge clk);
      #1;
      if (take) begin
        if (sent < n) begin
          take_bits(10, word_addr);
          req_addr_i = word_addr << 2;
        end else begin
          req_valid_i = 1'b0;
        end
      end
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    flush_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    rsp_ready_i  = 1'b1;
    burst_count  = 0;
    last_ar_addr = '0;
    beat_err     = 0;
    cycles       = 0;
    cycle_limit  = 1000;
    errors       = 0;
    test_err     = 0;
    tests_pass   = 0;
    tests_fail   = 0;
    lfsr         = 32'hdd90;
    for (int i = 0; i < PAT_MAX * 4; i++) begin
      pat[i] = 32'hffffffff;
    end
    $readmemh("icache_patterns.txt", pat);
    n_lines = 0;
    while (n_lines < PAT_MAX && pat[4*n_lines] != 32'hffffffff) begin
      n_lines++;
    end
    cycle_limit = 200 * (n_lines + RAND_NUM);
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;

    // ==================================================================
    // pattern part
    // ==================================================================
    cur_test = int'(pat[0]);
    for (int i = 0; i < n_lines; i++) begin
      if (int'(pat[4*i]) != cur_test) begin
        close_test(cur_test);
        cur_test = int'(pat[4*i]);
      end
      run_fetch(cur_test, pat[4*i+1], int'(pat[4*i+2]), 1'b1, int'(pat[4*i+3]));
    end
    if (n_lines > 0) begin
      close_test(cur_test);
    end

    // ==================================================================
    // random part, data and order only
    // ==================================================================
    run_stream(6, RAND_NUM);
    close_test(6);

    errors = errors + beat_err;
    $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
    if (errors == 0 && n_lines > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_axi_mem.sv
`default_nettype none

module tb_axi_mem (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          ar_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0] ar_addr_i,
  output logic                          ar_ready_o,
  output logic                          r_valid_o,
  output logic [icache_pkg::WORD_W-1:0] r_data_o,
  output logic                          r_last_o,
  input  logic                          r_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import icache_pkg::*;

  // cycles between seeing ar_valid and raising ar_ready
  localparam int PAUSE = 2;

  logic [ADDR_W-1:0] burst_addr;
  logic [ADDR_W-1:0] beat_addr;

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_last_o   = 1'b0;
    burst_addr = '0;
    beat_addr  = '0;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && ar_valid_i) begin
        burst_addr = ar_addr_i;
        repeat (PAUSE) @(posedge clk);
        #1 ar_ready_o = 1'b1;
        @(posedge clk);
        #1;
        ar_ready_o = 1'b0;
        // one beat per cycle while r_ready is high
        for (int b = 0; b <= BURST_LEN; b++) begin
          beat_addr = burst_addr + ADDR_W'(4 * b);
          r_valid_o = 1'b1;
          r_data_o  = (beat_addr >> 2) ^ 32'hdd90dd90;
          r_last_o  = (b == BURST_LEN);
          @(negedge clk);
          while (!r_ready_i) begin
            @(negedge clk);
          end
          @(posedge clk);
          #1;
        end
        r_valid_o = 1'b0;
        r_last_o  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: icache_top.sv
`default_nettype none

module icache_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  // fetch request
  input  logic                          req_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0] req_addr_i,
  output logic                          req_ready_o,
  // response
  output logic                          rsp_valid_o,
  output logic [icache_pkg::WORD_W-1:0] rsp_instr_o,
  input  logic                          rsp_ready_i,
  // bus read address
  output logic                          ar_valid_o,
  output logic [icache_pkg::ADDR_W-1:0] ar_addr_o,
  input  logic                          ar_ready_i,
  // bus read data
  input  logic                          r_valid_i,
  input  logic [icache_pkg::WORD_W-1:0] r_data_i,
  input  logic                          r_last_i,
  output logic                          r_ready_o
);

  import icache_pkg::*;

  logic [IDX_W-1:0]                rd_idx;
  logic [IDX_W-1:0]                s1_idx;
  logic [WAY_NUM-1:0][TAG_W-1:0]   tag_rd;
  logic [WAY_NUM-1:0]              valid_rd;
  logic [WAY_NUM-1:0][LINE_W-1:0]  data_rd;
  logic                            plru_rd;
  logic                            plru_we;
  logic                            plru_wdata;
  logic                            s1_valid;
  logic [ADDR_W-1:0]               s1_addr;
  logic                            miss;
  logic                            stall;
  logic                            refill_busy;
  logic [WAY_NUM-1:0]              line_we;
  logic [IDX_W-1:0]                line_idx;
  logic [TAG_W-1:0]                line_tag;
  logic [LINE_W-1:0]               line_data;

  // ====================================================================
  // stage 0 read index
  // ====================================================================
  assign s1_idx = s1_addr[IDX_LSB +: IDX_W];
  // otherwise re-read the stage-1 set so a refilled line shows up
  assign rd_idx = (req_valid_i && req_ready_o) ? req_addr_i[IDX_LSB +: IDX_W] : s1_idx;

  icache_lookup i_lookup (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_ready_o   (req_ready_o),
    .tag_rd_i      (tag_rd),
    .valid_rd_i    (valid_rd),
    .data_rd_i     (data_rd),
    .plru_rd_i     (plru_rd),
    .refill_busy_i (refill_busy),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_instr_o   (rsp_instr_o),
    .s1_valid_o    (s1_valid),
    .s1_addr_o     (s1_addr),
    .miss_o        (miss),
    .stall_o       (stall),
    .plru_we_o     (plru_we),
    .plru_wdata_o  (plru_wdata)
  );

  icache_refill i_refill (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .s1_valid_i  (s1_valid),
    .s1_addr_i   (s1_addr),
    .miss_i      (miss),
    .victim_i    (plru_rd),
    .ar_valid_o  (ar_valid_o),
    .ar_addr_o   (ar_addr_o),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_data_i    (r_data_i),
    .r_last_i    (r_last_i),
    .r_ready_o   (r_ready_o),
    .busy_o      (refill_busy),
    .line_we_o   (line_we),
    .line_idx_o  (line_idx),
    .line_tag_o  (line_tag),
    .line_data_o (line_data)
  );

  // ====================================================================
  // per-way storage
  // ====================================================================
  for (genvar w = 0; w < WAY_NUM; w++) begin : gen_way
    icache_ram #(
      .DEPTH (SET_NUM),
      .WIDTH (LINE_W)
    ) i_data_ram (
      .clk     (clk),
      .we_i    (line_we[w]),
      .waddr_i (line_idx),
      .wdata_i (line_data),
      .raddr_i (rd_idx),
      .rdata_o (data_rd[w])
    );

    icache_ram #(
      .DEPTH (SET_NUM),
      .WIDTH (TAG_W)
    ) i_tag_ram (
      .clk     (clk),
      .we_i    (line_we[w]),
      .waddr_i (line_idx),
      .wdata_i (line_tag),
      .raddr_i (rd_idx),
      .rdata_o (tag_rd[w])
    );

    icache_ram #(
      .DEPTH (SET_NUM),
      .WIDTH (1)
    ) i_valid_ram (
      .clk     (clk),
      .we_i    (line_we[w]),
      .waddr_i (line_idx),
      .wdata_i (1'b1),
      .raddr_i (rd_idx),
      .rdata_o (valid_rd[w])
    );
  end

  // one lru bit per set
  icache_ram #(
    .DEPTH (SET_NUM),
    .WIDTH (1)
  ) i_plru_ram (
    .clk     (clk),
    .we_i    (plru_we),
    .waddr_i (s1_idx),
    .wdata_i (plru_wdata),
    .raddr_i (rd_idx),
    .rdata_o (plru_rd)
  );

  // held stage 1 keeps its set on the read port
  stall_idx: assert property (@(posedge clk) disable iff (!rst_n)
    stall |-> (rd_idx == s1_idx));

  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o && !rsp_ready_i && !flush_i |=> rsp_valid_o && $stable(rsp_instr_o));

endmodule

`default_nettype wire

// File: icache_refill.sv
`default_nettype none

module icache_refill (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             flush_i,
  input  logic                             s1_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0]    s1_addr_i,
  input  logic                             miss_i,
  input  logic                             victim_i,
  output logic                             ar_valid_o,
  output logic [icache_pkg::ADDR_W-1:0]    ar_addr_o,
  input  logic                             ar_ready_i,
  input  logic                             r_valid_i,
  input  logic [icache_pkg::WORD_W-1:0]    r_data_i,
  input  logic                             r_last_i,
  output logic                             r_ready_o,
  output logic                             busy_o,
  output logic [icache_pkg::WAY_NUM-1:0]   line_we_o,
  output logic [icache_pkg::IDX_W-1:0]     line_idx_o,
  output logic [icache_pkg::TAG_W-1:0]     line_tag_o,
  output logic [icache_pkg::LINE_W-1:0]    line_data_o
);

  import icache_pkg::*;

  refill_state_e                     state_q;
  refill_state_e                     state_d;
  logic [WSEL_W-1:0]                 beat_q;
  logic [LINE_WORDS-2:0][WORD_W-1:0] beat_buf_q;
  logic                              flushed_q;
  logic                              last_beat;

  assign last_beat = (state_q == REFILL) && r_valid_i && r_last_i;

  // ====================================================================
  // refill FSM
  // ====================================================================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (s1_valid_i && miss_i && !flush_i) begin
          state_d = MISS;
        end
      end
      MISS: begin
        if (ar_ready_i) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (r_valid_i && r_last_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // burst keeps running after a flush, line is dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flushed_q <= 1'b0;
    end else if (state_q == IDLE) begin
      flushed_q <= 1'b0;
    end else if (flush_i) begin
      flushed_q <= 1'b1;
    end
  end

  // beat counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_q <= '0;
    end else if (state_q != REFILL) begin
      beat_q <= '0;
    end else if (r_valid_i) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  // first beats wait here, the last one goes straight to the RAM
  always_ff @(posedge clk) begin
    if ((state_q == REFILL) && r_valid_i && !r_last_i) begin
      beat_buf_q[beat_q] <= r_data_i;
    end
  end

  // ====================================================================
  // bus and line write
  // ====================================================================
  assign ar_valid_o = (state_q == MISS);
  assign ar_addr_o  = {s1_addr_i[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
  assign r_ready_o  = (state_q == REFILL);
  assign busy_o     = (state_q != IDLE);

  assign line_we_o   = (last_beat && !flushed_q && !flush_i) ?
                       (WAY_NUM'(1) << victim_i) : '0;
  assign line_idx_o  = s1_addr_i[IDX_LSB +: IDX_W];
  assign line_tag_o  = s1_addr_i[TAG_LSB +: TAG_W];
  assign line_data_o = {r_data_i, beat_buf_q};

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

  burst_len: assert property (@(posedge clk) disable iff (!rst_n)
    last_beat |-> (beat_q == WSEL_W'(BURST_LEN)));

endmodule

`default_nettype wire

// File: icache_lookup.sv
`default_nettype none

module icache_lookup (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic                                                   flush_i,
  input  logic                                                   req_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0]                          req_addr_i,
  output logic                                                   req_ready_o,
  input  logic [icache_pkg::WAY_NUM-1:0][icache_pkg::TAG_W-1:0]  tag_rd_i,
  input  logic [icache_pkg::WAY_NUM-1:0]                         valid_rd_i,
  input  logic [icache_pkg::WAY_NUM-1:0][icache_pkg::LINE_W-1:0] data_rd_i,
  input  logic                                                   plru_rd_i,
  input  logic                                                   refill_busy_i,
  input  logic                                                   rsp_ready_i,
  output logic                                                   rsp_valid_o,
  output logic [icache_pkg::WORD_W-1:0]                          rsp_instr_o,
  output logic                                                   s1_valid_o,
  output logic [icache_pkg::ADDR_W-1:0]                          s1_addr_o,
  output logic                                                   miss_o,
  output logic                                                   stall_o,
  output logic                                                   plru_we_o,
  output logic                                                   plru_wdata_o
);

  import icache_pkg::*;

  logic                              s1_valid_q;
  logic [ADDR_W-1:0]                 s1_addr_q;
  logic [TAG_W-1:0]                  s1_tag;
  logic [WAY_NUM-1:0]                match;
  logic                              hit;
  logic                              hit_way;
  logic [LINE_WORDS-1:0][WORD_W-1:0] hit_line;
  logic                              accept;

  // ====================================================================
  // stage 1 register
  // ====================================================================
  assign stall_o     = s1_valid_q && !(hit && rsp_ready_i);
  // no accept while refilling or on a flush cycle
  assign req_ready_o = !refill_busy_i && !flush_i && !stall_o;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
    end else if (flush_i) begin
      s1_valid_q <= 1'b0;
    end else if (!stall_o) begin
      s1_valid_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_addr_q <= req_addr_i;
    end
  end

  // ====================================================================
  // tag compare and word select
  // ====================================================================
  assign s1_tag = s1_addr_q[TAG_LSB +: TAG_W];

  always_comb begin
    hit_way = 1'b0;
    for (int w = 0; w < WAY_NUM; w++) begin
      match[w] = valid_rd_i[w] && (tag_rd_i[w] == s1_tag);
      if (match[w]) begin
        hit_way = w[0];
      end
    end
  end

  assign hit         = s1_valid_q && (|match);
  assign miss_o      = s1_valid_q && !(|match);
  assign hit_line    = data_rd_i[hit_way];
  assign rsp_valid_o = hit;
  assign rsp_instr_o = hit_line[s1_addr_q[WSEL_LSB +: WSEL_W]];

  assign s1_valid_o = s1_valid_q;
  assign s1_addr_o  = s1_addr_q;

  // lru bit points at the way not used last
  // only written when the handover changes it
  assign plru_we_o    = hit && rsp_ready_i && (plru_rd_i == hit_way);
  assign plru_wdata_o = !hit_way;

  // a line lives in one way only
  match_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    s1_valid_q |-> $onehot0(match));

endmodule

`default_nettype wire

// File: icache_ram.sv
`default_nettype none

module icache_ram #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  // contents start cleared
  logic [WIDTH-1:0] mem [DEPTH] = '{default: '0};
  logic [WIDTH-1:0] rdata_q;

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    // write-first on an address collision
    if (we_i && (waddr_i == raddr_i)) begin
      rdata_q <= wdata_i;
    end else begin
      rdata_q <= mem[raddr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

  // bus and instruction widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // ====================================================================
  // cache geometry
  // ====================================================================
  localparam int WAY_NUM    = 2;
  localparam int SET_NUM    = 16;
  localparam int LINE_WORDS = 4;

  // byte offset inside a line
  localparam int OFS_W  = 4;
  localparam int IDX_W  = 4;
  localparam int TAG_W  = ADDR_W - IDX_W - OFS_W;
  // word within a line
  localparam int WSEL_W = 2;
  localparam int LINE_W = LINE_WORDS * WORD_W;

  // ar length field, beats minus one
  localparam int BURST_LEN = LINE_WORDS - 1;

  // ====================================================================
  // address field positions
  // ====================================================================
  // word select sits above the two byte bits
  localparam int WSEL_LSB = 2;
  localparam int IDX_LSB  = OFS_W;
  localparam int TAG_LSB  = OFS_W + IDX_W;

  // refill FSM
  typedef enum logic [1:0] {
    IDLE,
    MISS,
    REFILL
  } refill_state_e;

endpackage

`default_nettype wire
